//--- verilog/prbs_pkg.sv
package prbs_pkg;

    // lfsr and history length
    localparam int n_prbs = 32;

    // number of parallel lanes
    localparam int n_channels = 16;

    // wide enough to count every lane in one cycle
    localparam int n_lane_bits = $clog2(n_channels) + 1;

    // tap mask, bit k set means state bit k feeds the xor
    typedef logic [n_prbs-1:0] prbs_eqn_t;

    // one bit per lane
    typedef logic [n_channels-1:0] lane_mask_t;

    // per-cycle sum over lanes
    typedef logic [n_lane_bits-1:0] lane_count_t;

    localparam logic [n_prbs-1:0] prbs_seed_base = 32'hace1_0000;

    // each lane gets its own nonzero seed
    function automatic logic [n_prbs-1:0] lane_seed(input int k);
        return prbs_seed_base ^ n_prbs'(k + 1);
    endfunction

endpackage

//--- verilog/bert_pkg.sv
package bert_pkg;

    localparam int count_width = 64;
    localparam int window_width = 16;

    // checker phases in test order
    typedef enum logic [1:0] {
        mode_reset  = 2'b00,
        mode_align  = 2'b01,
        mode_test   = 2'b10,
        mode_freeze = 2'b11
    } checker_mode_t;

    // error and total bit counters
    typedef logic [count_width-1:0] count_t;

    // align and test window lengths in cycles
    typedef logic [window_width-1:0] window_t;

endpackage

//--- verilog/prbs_cfg_if.sv
interface prbs_cfg_if;
    import prbs_pkg::*;

    // shared by generator and checker
    logic cke;
    prbs_eqn_t eqn;
    logic [1:0] inv_chicken;
    lane_mask_t chan_sel;

    modport source (
        output cke,
        output eqn,
        output inv_chicken,
        output chan_sel
    );

    // generator only needs the clock enable and the taps
    modport gen (
        input cke,
        input eqn
    );

    modport chk (
        input cke,
        input eqn,
        input inv_chicken,
        input chan_sel
    );

endinterface

//--- verilog/prbs_generator.sv
module prbs_generator (
    input  logic                 clk,
    input  logic                 rst,
    prbs_cfg_if.gen              cfg,
    input  logic                 tx_invert,
    input  prbs_pkg::lane_mask_t inject,
    output prbs_pkg::lane_mask_t tx_bits
);
    import prbs_pkg::*;

    // one fibonacci lfsr per lane, bit 0 holds the newest bit
    logic [n_prbs-1:0] lfsr [n_channels];
    lane_mask_t next_bit;
    lane_mask_t invert_mask;

    always_comb begin
        for (int k = 0; k < n_channels; k++) begin
            next_bit[k] = ^(lfsr[k] & cfg.eqn);
        end
    end

    assign invert_mask = {n_channels{tx_invert}};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < n_channels; k++) begin
                lfsr[k] <= lane_seed(k);
            end
            tx_bits <= '0;
        end else if (cfg.cke) begin
            for (int k = 0; k < n_channels; k++) begin
                lfsr[k] <= {lfsr[k][n_prbs-2:0], next_bit[k]};
            end
            // injection only touches the output, the sequence carries on
            tx_bits <= next_bit ^ invert_mask ^ inject;
        end
    end

endmodule

//--- verilog/prbs_checker_core.sv
module prbs_checker_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                cke,
    input  prbs_pkg::prbs_eqn_t eqn,
    input  logic [1:0]          inv_chicken,
    input  logic                rx_bit,
    output logic                err
);
    import prbs_pkg::*;

    // last n_prbs received bits, newest in bit 0
    logic [n_prbs-1:0] history;
    logic rx_adj;
    logic predicted;

    // inv_chicken[0] flips the incoming data
    assign rx_adj = rx_bit ^ inv_chicken[0];

    // inv_chicken[1] flips the prediction
    assign predicted = (^(history & eqn)) ^ inv_chicken[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
            err <= 1'b0;
        end else if (cke) begin
            history <= {history[n_prbs-2:0], rx_adj};
            err <= predicted ^ rx_adj;
        end
    end

endmodule

//--- verilog/prbs_checker.sv
module prbs_checker (
    input  logic                    clk,
    input  logic                    rst,
    prbs_cfg_if.chk                 cfg,
    input  prbs_pkg::lane_mask_t    rx_bits,
    input  bert_pkg::checker_mode_t checker_mode,
    output bert_pkg::count_t        err_bits,
    output bert_pkg::count_t        total_bits,
    output logic                    error_in_frame,
    output prbs_pkg::lane_mask_t    prbs_flags
);
    import prbs_pkg::*;
    import bert_pkg::*;

    lane_mask_t err_flags;
    lane_count_t err_count;
    lane_count_t tot_count;

    for (genvar k = 0; k < n_channels; k++) begin : g_lane
        prbs_checker_core prbs_checker_core_i (
            .clk(clk),
            .rst(rst),
            .cke(cfg.cke),
            .eqn(cfg.eqn),
            .inv_chicken(cfg.inv_chicken),
            .rx_bit(rx_bits[k]),
            .err(err_flags[k])
        );
    end

    assign prbs_flags = err_flags;

    // any lane, selected or not
    assign error_in_frame = |err_flags;

    // errors and checked bits this cycle over the selected lanes
    always_comb begin
        err_count = '0;
        tot_count = '0;
        for (int i = 0; i < n_channels; i++) begin
            err_count = err_count + lane_count_t'(err_flags[i] & cfg.chan_sel[i]);
            tot_count = tot_count + lane_count_t'(cfg.chan_sel[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            err_bits <= '0;
            total_bits <= '0;
        end else begin
            case (checker_mode)
                mode_reset: begin
                    err_bits <= '0;
                    total_bits <= '0;
                end
                mode_test: begin
                    err_bits <= err_bits + count_t'(err_count);
                    total_bits <= total_bits + count_t'(tot_count);
                end
                // align and freeze hold
                default: begin
                    err_bits <= err_bits;
                    total_bits <= total_bits;
                end
            endcase
        end
    end

endmodule

//--- verilog/bert_timer.sv
module bert_timer (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  bert_pkg::window_t length,
    output logic              expired
);
    import bert_pkg::*;

    window_t count;
    logic running;

    // length of zero is not supported, it wraps to a full window
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            running <= 1'b0;
        end else if (load) begin
            count <= length - window_t'(1);
            running <= 1'b1;
        end else if (running && count != '0) begin
            count <= count - window_t'(1);
        end
    end

    // stays high at zero until reloaded
    assign expired = running && (count == '0);

endmodule

//--- verilog/bert_sequencer.sv
module bert_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  bert_pkg::window_t       align_cycles,
    input  bert_pkg::window_t       test_cycles,
    input  logic                    expired,
    output logic                    load,
    output bert_pkg::window_t       length,
    output bert_pkg::checker_mode_t checker_mode,
    output logic                    busy,
    output logic                    done
);
    import bert_pkg::*;

    // state is the checker mode itself, freeze doubles as idle
    checker_mode_t state;
    checker_mode_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            mode_freeze: begin
                if (start) begin
                    state_next = mode_reset;
                end
            end
            mode_reset: begin
                state_next = mode_align;
            end
            mode_align: begin
                if (expired) begin
                    state_next = mode_test;
                end
            end
            default: begin
                if (expired) begin
                    state_next = mode_freeze;
                end
            end
        endcase
    end

    // timer is loaded one cycle ahead so expired lands on the last phase cycle
    assign load = (state == mode_reset) || (state == mode_align && expired);
    assign length = (state == mode_reset) ? align_cycles : test_cycles;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mode_freeze;
            done <= 1'b0;
        end else begin
            state <= state_next;
            done <= (state == mode_test) && expired;
        end
    end

    assign checker_mode = state;
    assign busy = (state != mode_freeze);

endmodule

//--- verilog/bert_top.sv
module bert_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    cke,
    input  logic                    tx_invert,
    input  prbs_pkg::prbs_eqn_t     eqn,
    input  prbs_pkg::lane_mask_t    chan_sel,
    input  prbs_pkg::lane_mask_t    inject,
    input  logic [1:0]              inv_chicken,
    input  bert_pkg::window_t       align_cycles,
    input  bert_pkg::window_t       test_cycles,
    output logic                    busy,
    output logic                    done,
    output logic                    error_in_frame,
    output bert_pkg::checker_mode_t checker_mode,
    output bert_pkg::count_t        err_bits,
    output bert_pkg::count_t        total_bits,
    output prbs_pkg::lane_mask_t    prbs_flags
);
    import prbs_pkg::*;
    import bert_pkg::*;

    prbs_cfg_if cfg ();

    // generator output straight into the checker
    lane_mask_t loop_bits;
    logic timer_load;
    window_t timer_length;
    logic timer_expired;

    assign cfg.cke = cke;
    assign cfg.eqn = eqn;
    assign cfg.inv_chicken = inv_chicken;
    assign cfg.chan_sel = chan_sel;

    prbs_generator prbs_generator_i (
        .clk(clk),
        .rst(rst),
        .cfg(cfg),
        .tx_invert(tx_invert),
        .inject(inject),
        .tx_bits(loop_bits)
    );

    prbs_checker prbs_checker_i (
        .clk(clk),
        .rst(rst),
        .cfg(cfg),
        .rx_bits(loop_bits),
        .checker_mode(checker_mode),
        .err_bits(err_bits),
        .total_bits(total_bits),
        .error_in_frame(error_in_frame),
        .prbs_flags(prbs_flags)
    );

    bert_timer bert_timer_i (
        .clk(clk),
        .rst(rst),
        .load(timer_load),
        .length(timer_length),
        .expired(timer_expired)
    );

    bert_sequencer bert_sequencer_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .align_cycles(align_cycles),
        .test_cycles(test_cycles),
        .expired(timer_expired),
        .load(timer_load),
        .length(timer_length),
        .checker_mode(checker_mode),
        .busy(busy),
        .done(done)
    );

endmodule

//--- bench/bert_assertions.sv
module bert_assertions (
    input logic                    clk,
    input logic                    rst,
    input bert_pkg::checker_mode_t checker_mode,
    input logic                    done,
    input bert_pkg::count_t        err_bits,
    input bert_pkg::count_t        total_bits
);
    import bert_pkg::*;

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // one reset cycle leaves both counters cleared in align
    reset_phase: assert property (@(posedge clk) disable iff (rst)
        checker_mode == mode_reset |=> checker_mode == mode_align
            && err_bits == '0 && total_bits == '0)
        else $error("reset phase did not last one cycle or left the counters set");

    freeze_hold: assert property (@(posedge clk) disable iff (rst)
        checker_mode == mode_freeze |=> $stable(err_bits) && $stable(total_bits))
        else $error("counters changed during freeze");

    // every counted error is also a counted bit
    err_bound: assert property (@(posedge clk) disable iff (rst) err_bits <= total_bits)
        else $error("err_bits exceeds total_bits");

endmodule

// top level is where sequencer and checker outputs meet
bind bert_top bert_assertions bert_assertions_i (
    .clk(clk),
    .rst(rst),
    .checker_mode(checker_mode),
    .done(done),
    .err_bits(err_bits),
    .total_bits(total_bits)
);

//--- bench/bert_tb.sv
module bert_clock (
    output logic clk
);
    // period of 4 starting low
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end
endmodule

module bert_tb;
    import prbs_pkg::*;
    import bert_pkg::*;

    // slack on top of align plus test before done counts as lost
    localparam int done_margin = 40;
    localparam int hold_cycles = 6;

    logic clk;
    logic rst;
    logic start;
    logic cke;
    logic tx_invert;
    prbs_eqn_t eqn;
    lane_mask_t chan_sel;
    lane_mask_t inject;
    logic [1:0] inv_chicken;
    window_t align_cycles;
    window_t test_cycles;
    logic busy;
    logic done;
    logic error_in_frame;
    checker_mode_t checker_mode;
    count_t err_bits;
    count_t total_bits;
    lane_mask_t prbs_flags;

    // fields of the current vector line
    prbs_eqn_t v_eqn;
    lane_mask_t v_chan_sel;
    logic [1:0] v_inv;
    logic v_txinv;
    int v_lane;
    int v_offset;
    int v_align;
    int v_test;
    count_t v_err;
    count_t v_total;
    int vector_count;

    bert_clock bert_clock_i (
        .clk(clk)
    );

    bert_top bert_top_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .cke(cke),
        .tx_invert(tx_invert),
        .eqn(eqn),
        .chan_sel(chan_sel),
        .inject(inject),
        .inv_chicken(inv_chicken),
        .align_cycles(align_cycles),
        .test_cycles(test_cycles),
        .busy(busy),
        .done(done),
        .error_in_frame(error_in_frame),
        .checker_mode(checker_mode),
        .err_bits(err_bits),
        .total_bits(total_bits),
        .prbs_flags(prbs_flags)
    );

    task automatic report_failure(input string what);
        $display("Error at time %0t: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input count_t expected, input count_t actual);
        assert (actual == expected) else begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("Fail at time %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_mode(input checker_mode_t expected, input checker_mode_t actual);
        assert (actual == expected) else begin
            $display("Fail at time %0t: checker_mode expected %s, got %s", $time,
                     expected.name(), actual.name());
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // one full start..done run plus the idle hold after it
    task automatic run_vector();
        int cycles;
        int test_seen;
        int limit;
        logic all_err;
        logic frame_seen;
        lane_mask_t flags_seen;
        lane_mask_t exp_flags;

        cycles = 0;
        test_seen = 0;
        frame_seen = 1'b0;
        flags_seen = '0;
        limit = v_align + v_test + done_margin;

        // lanes share one config so a lane errors on every bit or never
        all_err = v_inv[1] ^ ((v_txinv != v_inv[0]) && ($countones(v_eqn) % 2 == 0));
        exp_flags = all_err ? '1 : '0;
        if (v_offset != 0) begin
            exp_flags = exp_flags | (lane_mask_t'(1) << v_lane);
        end

        @(negedge clk);
        eqn = v_eqn;
        chan_sel = v_chan_sel;
        inv_chicken = v_inv;
        tx_invert = v_txinv;
        align_cycles = window_t'(v_align);
        test_cycles = window_t'(v_test);
        check_bit("busy", 1'b0, busy);
        check_mode(mode_freeze, checker_mode);

        @(negedge clk);
        start = 1'b1;

        @(negedge clk);
        start = 1'b0;
        check_bit("busy", 1'b1, busy);
        check_mode(mode_reset, checker_mode);

        // counters from the last run are gone after the reset phase
        @(negedge clk);
        check_mode(mode_align, checker_mode);
        check_value("err_bits", '0, err_bits);
        check_value("total_bits", '0, total_bits);

        while (!done) begin
            if (cycles >= limit) begin
                report_failure("timed out waiting for done");
            end
            check_bit("busy", 1'b1, busy);
            @(negedge clk);
            cycles++;
            start = 1'b0;
            inject = '0;
            if (checker_mode == mode_test) begin
                test_seen++;
                flags_seen = flags_seen | prbs_flags;
                frame_seen = frame_seen | error_in_frame;
                // a second start mid-window must not restart the run
                if (test_seen == 5) begin
                    start = 1'b1;
                end
                if (v_offset != 0 && test_seen == v_offset) begin
                    inject = lane_mask_t'(1) << v_lane;
                end
            end
        end

        check_bit("busy", 1'b0, busy);
        check_mode(mode_freeze, checker_mode);
        check_value("test window cycles", count_t'(v_test), count_t'(test_seen));
        check_value("err_bits", v_err, err_bits);
        check_value("total_bits", v_total, total_bits);
        check_value("prbs_flags", count_t'(exp_flags), count_t'(flags_seen));
        check_bit("error_in_frame seen", |exp_flags, frame_seen);

        @(negedge clk);
        check_bit("done", 1'b0, done);
        repeat (hold_cycles) begin
            check_mode(mode_freeze, checker_mode);
            check_value("err_bits", v_err, err_bits);
            check_value("total_bits", v_total, total_bits);
            @(negedge clk);
        end
    endtask

    initial begin
        int fd;
        int fields;
        string line;

        rst = 1'b1;
        start = 1'b0;
        cke = 1'b1;
        tx_invert = 1'b0;
        eqn = 32'h4800_0000;
        chan_sel = '1;
        inject = '0;
        inv_chicken = 2'b00;
        align_cycles = window_t'(40);
        test_cycles = window_t'(100);
        vector_count = 0;

        // two rising edges in reset
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // idle state straight out of reset
        check_mode(mode_freeze, checker_mode);
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_value("err_bits", '0, err_bits);
        check_value("total_bits", '0, total_bits);

        fd = $fopen("bench/bert_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("could not open bench/bert_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h %h %d %d %d %d %d %d", v_eqn, v_chan_sel,
                             v_inv, v_txinv, v_lane, v_offset, v_align, v_test, v_err, v_total);
            if (fields == 10) begin
                vector_count++;
                run_vector();
            end else if (fields > 0) begin
                report_failure("malformed line in the vector file");
            end
        end
        $fclose(fd);

        if (vector_count == 0) begin
            report_failure("the vector file holds no test cases");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- bench/bert_vectors.txt
# eqn(hex) chan_sel(hex) inv_chicken(hex) tx_invert(hex) inject_lane inject_offset
# align_cycles test_cycles exp_err_bits exp_total_bits (decimal), offset 0 means no inject
48000000 ffff 0 0 0 0 40 100 0 1600
00420000 00f0 0 0 0 0 40 80 0 320
00000060 8001 1 1 0 0 36 50 0 100
80200002 0a5a 0 0 0 0 34 64 0 384
48000000 ffff 0 0 3 80 40 200 3 3200
80200002 0020 0 0 5 100 40 200 4 200
48000000 00ff 0 0 12 60 40 150 0 1200
00000060 ffff 0 0 9 70 34 140 3 2240
48000000 ffff 2 0 0 0 40 100 1600 1600
80200002 0f0f 3 1 0 0 40 60 480 480
00420000 ffff 0 1 0 0 40 90 1440 1440
80200002 ffff 1 0 0 0 40 90 0 1440
48000000 0000 0 0 0 0 40 70 0 0

//--- files.f
verilog/prbs_pkg.sv
verilog/bert_pkg.sv
verilog/prbs_cfg_if.sv
verilog/prbs_generator.sv
verilog/prbs_checker_core.sv
verilog/prbs_checker.sv
verilog/bert_timer.sv
verilog/bert_sequencer.sv
verilog/bert_top.sv
bench/bert_assertions.sv
bench/bert_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the bert testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bert_tb -f files.f -o bert_sim
./obj_dir/bert_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure"
    exit 1
fi
